/* common/id_pkg.sv */
package id_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Pool sizes
    ///////////////////////////////////////////////////////////////////////

    // Instruction IDs that can be in flight at once
    localparam int MAX_IDS = 8;

    // Bits needed to name one ID
    localparam int LOG2_MAX_IDS = 3;

    // One extra bit so a completely full pool can still be counted
    localparam int ID_COUNT_W = LOG2_MAX_IDS + 1;

    // Instructions that can leave the pipeline in one cycle
    localparam int RETIRE_PORTS = 2;

    // Select width over the retire ports
    localparam int LOG2_RETIRE_PORTS = 1;

    ///////////////////////////////////////////////////////////////////////
    // Shared types
    ///////////////////////////////////////////////////////////////////////

    // Wrapping instruction ID
    typedef logic [LOG2_MAX_IDS-1:0] id_t;

    // In-flight count whose top bit marks a full pool
    typedef logic [ID_COUNT_W-1:0] count_t;

    // PC or raw instruction word
    typedef logic [31:0] word_t;

    // Architectural register number from x0 to x31
    typedef logic [4:0] reg_addr_t;

endpackage

/* src/id_allocator.sv */
`timescale 1ns/1ps

module id_allocator (
    input  logic           clk,
    input  logic           rst,
    input  logic           pc_id_assigned,
    input  logic           fetch_complete,
    input  logic           decode_advance,
    input  logic           instruction_issued,
    input  logic           fetch_flush,
    input  id_pkg::count_t retire_count_next,
    output id_pkg::id_t    pc_id,
    output id_pkg::id_t    fetch_id,
    output id_pkg::id_t    decode_id,
    output id_pkg::id_t    issue_id,
    output logic           pc_id_available,
    output logic           decode_valid,
    output id_pkg::count_t post_issue_count
);
    import id_pkg::*;

    // Negative count of IDs fetched but not yet decoded
    count_t fetched_count_neg;
    // Assigned at PC generation but not yet issued
    count_t pre_issue_count;
    count_t pre_issue_count_next;
    count_t post_issue_count_next;
    // Registered sum of both halves
    count_t inflight_count;

    ///////////////////////////////////////////////////////////////////////
    // ID pointers
    ///////////////////////////////////////////////////////////////////////

    // Oldest ID that has not been issued yet
    // Issue always takes this one, so it just steps forward
    always_ff @(posedge clk) begin
        if (rst)
            issue_id <= '0;
        else if (instruction_issued)
            issue_id <= issue_id + id_t'(1);
    end

    // Front-end pointers wrap freely
    // A flush rewinds them all to the oldest unissued ID
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_id <= '0;
            fetch_id <= '0;
            decode_id <= '0;
        end else if (fetch_flush) begin
            pc_id <= issue_id;
            fetch_id <= issue_id;
            decode_id <= issue_id;
        end else begin
            pc_id <= pc_id + id_t'(pc_id_assigned);
            fetch_id <= fetch_id + id_t'(fetch_complete);
            decode_id <= decode_id + id_t'(decode_advance);
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Counters
    ///////////////////////////////////////////////////////////////////////

    // Goes negative on fetch, so the MSB means decode has an ID waiting
    always_ff @(posedge clk) begin
        if (rst || fetch_flush)
            fetched_count_neg <= '0;
        else
            fetched_count_neg <= fetched_count_neg + count_t'(decode_advance)
                                 - count_t'(fetch_complete);
    end

    assign pre_issue_count_next = pre_issue_count + count_t'(pc_id_assigned)
                                  - count_t'(instruction_issued);
    assign post_issue_count_next = post_issue_count + count_t'(instruction_issued)
                                   - retire_count_next;

    // Flush drops everything still ahead of issue
    always_ff @(posedge clk) begin
        if (rst || fetch_flush)
            pre_issue_count <= '0;
        else
            pre_issue_count <= pre_issue_count_next;
    end

    // Only retirement brings this one down
    always_ff @(posedge clk) begin
        if (rst)
            post_issue_count <= '0;
        else
            post_issue_count <= post_issue_count_next;
    end

    // Issued IDs survive a flush
    always_ff @(posedge clk) begin
        if (rst)
            inflight_count <= '0;
        else if (fetch_flush)
            inflight_count <= post_issue_count_next;
        else
            inflight_count <= pre_issue_count_next + post_issue_count_next;
    end

    // Pool full once the count reaches MAX_IDS
    assign pc_id_available = ~inflight_count[LOG2_MAX_IDS];
    assign decode_valid = fetched_count_neg[LOG2_MAX_IDS];

endmodule

/* src/metadata_tables.sv */
`timescale 1ns/1ps

module metadata_tables (
    input  logic              clk,
    input  logic              pc_id_assigned,
    input  logic              fetch_complete,
    input  logic              decode_advance,
    input  logic              decode_uses_rd,
    input  id_pkg::id_t       pc_id,
    input  id_pkg::id_t       fetch_id,
    input  id_pkg::id_t       decode_id,
    input  id_pkg::word_t     if_pc,
    input  id_pkg::word_t     fetch_instruction,
    input  id_pkg::reg_addr_t decode_rd_addr,
    input  id_pkg::id_t       retire_ids_next [id_pkg::RETIRE_PORTS],
    output id_pkg::word_t     decode_pc,
    output id_pkg::word_t     decode_instruction,
    output logic              retire_uses_rd [id_pkg::RETIRE_PORTS]
);
    import id_pkg::*;

    // Small distributed tables with one entry per ID
    word_t pc_table [MAX_IDS];
    word_t instruction_table [MAX_IDS];
    logic uses_rd_table [MAX_IDS];

    ///////////////////////////////////////////////////////////////////////
    // Writes
    ///////////////////////////////////////////////////////////////////////

    // PC captured when the ID is handed out
    always_ff @(posedge clk) begin
        if (pc_id_assigned)
            pc_table[pc_id] <= if_pc;
    end

    // Instruction word arrives later when fetch returns
    always_ff @(posedge clk) begin
        if (fetch_complete)
            instruction_table[fetch_id] <= fetch_instruction;
    end

    // x0 writes are discarded, so they do not count as a destination
    always_ff @(posedge clk) begin
        if (decode_advance)
            uses_rd_table[decode_id] <= decode_uses_rd && (|decode_rd_addr);
    end

    ///////////////////////////////////////////////////////////////////////
    // Reads
    ///////////////////////////////////////////////////////////////////////

    assign decode_pc = pc_table[decode_id];
    assign decode_instruction = instruction_table[decode_id];

    // One read port per retire candidate
    always_comb begin
        for (int i = 0; i < RETIRE_PORTS; i++)
            retire_uses_rd[i] = uses_rd_table[retire_ids_next[i]];
    end

endmodule

/* retire/writeback_tracker.sv */
`timescale 1ns/1ps

module writeback_tracker (
    input  logic        clk,
    input  logic        rst,
    input  logic        instruction_issued,
    input  logic        issue_pending_wb,
    input  logic        wb_valid,
    input  id_pkg::id_t issue_id,
    input  id_pkg::id_t wb_id,
    input  id_pkg::id_t retire_ids_next [id_pkg::RETIRE_PORTS],
    output logic        retire_wb_pending [id_pkg::RETIRE_PORTS]
);
    import id_pkg::*;

    // Write port 0 is issue and port 1 is the writeback bus
    localparam int WRITE_PORTS = 2;

    logic toggle_en [WRITE_PORTS];
    id_t toggle_addr [WRITE_PORTS];
    // Combined flip mask across all write ports
    logic [MAX_IDS-1:0] toggle_mask;
    // Set means a multicycle result is still outstanding
    logic [MAX_IDS-1:0] pending_bits;

    ///////////////////////////////////////////////////////////////////////
    // Toggle ports
    ///////////////////////////////////////////////////////////////////////

    // Only multicycle register writers mark themselves on issue
    assign toggle_en[0] = instruction_issued && issue_pending_wb;
    assign toggle_addr[0] = issue_id;
    assign toggle_en[1] = wb_valid;
    assign toggle_addr[1] = wb_id;

    // Each port flips its own bit with XOR so both ports may fire together
    always_comb begin
        toggle_mask = '0;
        for (int p = 0; p < WRITE_PORTS; p++) begin
            if (toggle_en[p])
                toggle_mask[toggle_addr[p]] = ~toggle_mask[toggle_addr[p]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            pending_bits <= '0;
        else
            pending_bits <= pending_bits ^ toggle_mask;
    end

    ///////////////////////////////////////////////////////////////////////
    // Read ports
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < RETIRE_PORTS; i++)
            retire_wb_pending[i] = pending_bits[retire_ids_next[i]];
    end

endmodule

/* retire/retire_select.sv */
`timescale 1ns/1ps

module retire_select (
    input  logic           clk,
    input  logic           rst,
    input  logic           exception_pending,
    input  id_pkg::count_t post_issue_count,
    input  logic           retire_uses_rd [id_pkg::RETIRE_PORTS],
    input  logic           retire_wb_pending [id_pkg::RETIRE_PORTS],
    output id_pkg::id_t    retire_ids_next [id_pkg::RETIRE_PORTS],
    output id_pkg::id_t    retire_ids [id_pkg::RETIRE_PORTS],
    output id_pkg::count_t retire_count_next,
    output id_pkg::count_t retire_count,
    output logic           retire_port_valid [id_pkg::RETIRE_PORTS],
    output logic           retire_rd_valid,
    output id_pkg::id_t    retire_rd_id
);
    import id_pkg::*;

    logic port_valid_next [RETIRE_PORTS];
    // Running state across ports from the oldest
    logic contiguous;
    logic rd_found;
    logic [LOG2_RETIRE_PORTS-1:0] rd_sel;

    ///////////////////////////////////////////////////////////////////////
    // Retire decision
    ///////////////////////////////////////////////////////////////////////

    // Ports retire as one unbroken block starting at port 0
    // At most one register writer per cycle
    // Pending exception limits it to a single instruction
    always_comb begin
        contiguous = 1'b1;
        rd_found = 1'b0;
        for (int i = 0; i < RETIRE_PORTS; i++) begin
            port_valid_next[i] = (post_issue_count > count_t'(i)) && !retire_wb_pending[i]
                                 && (!retire_uses_rd[i] || !rd_found) && contiguous;
            rd_found = rd_found | (port_valid_next[i] & retire_uses_rd[i]);
            contiguous = contiguous & port_valid_next[i] & ~exception_pending;
        end
    end

    // Lowest retiring writer wins by scanning from the top so it lands last
    always_comb begin
        rd_sel = '0;
        for (int i = RETIRE_PORTS - 1; i >= 0; i--) begin
            if (port_valid_next[i] && retire_uses_rd[i])
                rd_sel = LOG2_RETIRE_PORTS'(i);
        end
    end

    always_comb begin
        retire_count_next = '0;
        for (int i = 0; i < RETIRE_PORTS; i++)
            retire_count_next = retire_count_next + count_t'(port_valid_next[i]);
    end

    ///////////////////////////////////////////////////////////////////////
    // Registered state and outputs
    ///////////////////////////////////////////////////////////////////////

    // Port i always trails port 0 by i
    // retire_ids shows the IDs that the registered outputs refer to
    always_ff @(posedge clk) begin
        for (int i = 0; i < RETIRE_PORTS; i++) begin
            if (rst) begin
                retire_ids_next[i] <= id_t'(i);
                retire_ids[i] <= id_t'(i);
            end else begin
                retire_ids_next[i] <= retire_ids_next[i] + id_t'(retire_count_next);
                retire_ids[i] <= retire_ids_next[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_count <= '0;
            retire_rd_valid <= 1'b0;
            for (int i = 0; i < RETIRE_PORTS; i++)
                retire_port_valid[i] <= 1'b0;
        end else begin
            retire_count <= retire_count_next;
            retire_rd_valid <= rd_found;
            for (int i = 0; i < RETIRE_PORTS; i++)
                retire_port_valid[i] <= port_valid_next[i];
        end
    end

    // Only meaningful alongside retire_rd_valid
    always_ff @(posedge clk) begin
        retire_rd_id <= retire_ids_next[rd_sel];
    end

endmodule

/* src/id_manager.sv */
`timescale 1ns/1ps

module id_manager (
    input  logic              clk,
    input  logic              rst,
    // Fetch side
    input  logic              pc_id_assigned,
    input  id_pkg::word_t     if_pc,
    input  logic              fetch_complete,
    input  id_pkg::word_t     fetch_instruction,
    input  logic              fetch_flush,
    output id_pkg::id_t       pc_id,
    output id_pkg::id_t       fetch_id,
    output logic              pc_id_available,
    // Decode
    input  logic              decode_advance,
    input  logic              decode_uses_rd,
    input  id_pkg::reg_addr_t decode_rd_addr,
    output logic              decode_valid,
    output id_pkg::id_t       decode_id,
    output id_pkg::word_t     decode_pc,
    output id_pkg::word_t     decode_instruction,
    // Issue and writeback
    input  logic              instruction_issued,
    input  logic              issue_pending_wb,
    input  logic              wb_valid,
    input  id_pkg::id_t       wb_id,
    input  logic              exception_pending,
    // Retire
    output id_pkg::id_t       retire_ids [id_pkg::RETIRE_PORTS],
    output logic              retire_port_valid [id_pkg::RETIRE_PORTS],
    output id_pkg::count_t    retire_count,
    output logic              retire_rd_valid,
    output id_pkg::id_t       retire_rd_id,
    output id_pkg::count_t    post_issue_count
);
    import id_pkg::*;

    id_t issue_id;
    id_t retire_ids_next [RETIRE_PORTS];
    count_t retire_count_next;
    logic retire_uses_rd [RETIRE_PORTS];
    logic retire_wb_pending [RETIRE_PORTS];

    ///////////////////////////////////////////////////////////////////////
    // Allocation and metadata
    ///////////////////////////////////////////////////////////////////////

    id_allocator i_id_allocator (
        .clk                (clk),
        .rst                (rst),
        .pc_id_assigned     (pc_id_assigned),
        .fetch_complete     (fetch_complete),
        .decode_advance     (decode_advance),
        .instruction_issued (instruction_issued),
        .fetch_flush        (fetch_flush),
        .retire_count_next  (retire_count_next),
        .pc_id              (pc_id),
        .fetch_id           (fetch_id),
        .decode_id          (decode_id),
        .issue_id           (issue_id),
        .pc_id_available    (pc_id_available),
        .decode_valid       (decode_valid),
        .post_issue_count   (post_issue_count)
    );

    metadata_tables i_metadata_tables (
        .clk                (clk),
        .pc_id_assigned     (pc_id_assigned),
        .fetch_complete     (fetch_complete),
        .decode_advance     (decode_advance),
        .decode_uses_rd     (decode_uses_rd),
        .pc_id              (pc_id),
        .fetch_id           (fetch_id),
        .decode_id          (decode_id),
        .if_pc              (if_pc),
        .fetch_instruction  (fetch_instruction),
        .decode_rd_addr     (decode_rd_addr),
        .retire_ids_next    (retire_ids_next),
        .decode_pc          (decode_pc),
        .decode_instruction (decode_instruction),
        .retire_uses_rd     (retire_uses_rd)
    );

    ///////////////////////////////////////////////////////////////////////
    // Writeback tracking and retirement
    ///////////////////////////////////////////////////////////////////////

    writeback_tracker i_writeback_tracker (
        .clk                (clk),
        .rst                (rst),
        .instruction_issued (instruction_issued),
        .issue_pending_wb   (issue_pending_wb),
        .wb_valid           (wb_valid),
        .issue_id           (issue_id),
        .wb_id              (wb_id),
        .retire_ids_next    (retire_ids_next),
        .retire_wb_pending  (retire_wb_pending)
    );

    retire_select i_retire_select (
        .clk                (clk),
        .rst                (rst),
        .exception_pending  (exception_pending),
        .post_issue_count   (post_issue_count),
        .retire_uses_rd     (retire_uses_rd),
        .retire_wb_pending  (retire_wb_pending),
        .retire_ids_next    (retire_ids_next),
        .retire_ids         (retire_ids),
        .retire_count_next  (retire_count_next),
        .retire_count       (retire_count),
        .retire_port_valid  (retire_port_valid),
        .retire_rd_valid    (retire_rd_valid),
        .retire_rd_id       (retire_rd_id)
    );

endmodule

/* sim/id_manager_tests.svh */
// Each row holds PC, instruction word, uses rd, rd, multicycle flag and writeback delay
logic [31:0] row_pc [NUM_ROWS];
logic [31:0] row_instr [NUM_ROWS];
bit row_uses_rd [NUM_ROWS];
logic [4:0] row_rd [NUM_ROWS];
bit row_multi [NUM_ROWS];
int row_delay [NUM_ROWS];
int test_start_errors;
string test_name;

task automatic set_row(int r, logic [31:0] pc, logic [31:0] instr, bit uses_rd,
                       logic [4:0] rd, bit multi);
    row_pc[r] = pc;
    row_instr[r] = instr;
    row_uses_rd[r] = uses_rd;
    row_rd[r] = rd;
    row_multi[r] = multi;
    // Writeback arrives 1 to 4 cycles after issue
    row_delay[r] = multi ? 1 + int'($unsigned($random(seed)) % 4) : 0;
endtask

task automatic init_table();
    set_row(0,  32'h0000_1000, 32'h0010_0093, 1, 5'd1,  0);
    set_row(1,  32'h0000_1004, 32'h0020_0113, 1, 5'd2,  0);
    set_row(2,  32'h0000_1008, 32'h0000_0013, 1, 5'd0,  0);
    set_row(3,  32'h0000_100c, 32'h0020_a023, 0, 5'd0,  0);
    set_row(4,  32'h0000_1010, 32'h0031_01b3, 1, 5'd3,  0);
    set_row(5,  32'h0000_1014, 32'h0041_8233, 1, 5'd4,  0);
    set_row(6,  32'h0000_1018, 32'h0000_0063, 0, 5'd0,  0);
    set_row(7,  32'h0000_101c, 32'h0052_02b3, 1, 5'd5,  0);
    set_row(8,  32'h0000_2000, 32'h0262_8333, 1, 5'd6,  1);
    set_row(9,  32'h0000_2004, 32'h0000_0013, 1, 5'd0,  0);
    set_row(10, 32'h0000_2008, 32'h0263_43b3, 1, 5'd7,  1);
    set_row(11, 32'h0000_200c, 32'h0070_2023, 0, 5'd0,  0);
    set_row(12, 32'h0000_3000, 32'h0273_4433, 1, 5'd8,  1);
    set_row(13, 32'h0000_3004, 32'h0014_0493, 1, 5'd9,  0);
    set_row(14, 32'h0000_3008, 32'h0014_8513, 1, 5'd10, 0);
    set_row(15, 32'h0000_300c, 32'h0015_0593, 1, 5'd11, 0);
    set_row(16, 32'h0000_3010, 32'h0015_8613, 1, 5'd12, 0);
endtask

task automatic start_test(string name);
    test_name = name;
    test_start_errors = errors;
endtask

task automatic finish_test();
    tests_run++;
    if (errors == test_start_errors) begin
        $display("test %s: passed", test_name);
    end else begin
        tests_failed++;
        $display("test %s: failed with %0d errors", test_name, errors - test_start_errors);
    end
endtask

//////////////////////////////////////////////////////////////////////
// Pipeline events of one strobe cycle each
//////////////////////////////////////////////////////////////////////

task automatic assign_row(int r);
    if (!pc_id_available)
        report_mismatch("pc_id_available", 32'd1, 32'(pc_id_available));
    if (pc_id != m_pc_ptr)
        report_mismatch("pc_id", 32'(m_pc_ptr), 32'(pc_id));
    pc_id_assigned = 1'b1;
    if_pc = row_pc[r];
    next_cycle();
    pc_id_assigned = 1'b0;
    m_pc_ptr = m_pc_ptr + 3'd1;
endtask

task automatic fetch_row(int r);
    if (fetch_id != m_fetch_ptr)
        report_mismatch("fetch_id", 32'(m_fetch_ptr), 32'(fetch_id));
    fetch_complete = 1'b1;
    fetch_instruction = row_instr[r];
    next_cycle();
    fetch_complete = 1'b0;
    m_fetch_ptr = m_fetch_ptr + 3'd1;
endtask

task automatic decode_row(int r);
    if (!decode_valid)
        report_mismatch("decode_valid", 32'd1, 32'(decode_valid));
    if (decode_id != m_decode_ptr)
        report_mismatch("decode_id", 32'(m_decode_ptr), 32'(decode_id));
    if (decode_pc != row_pc[r])
        report_mismatch("decode_pc", row_pc[r], decode_pc);
    if (decode_instruction != row_instr[r])
        report_mismatch("decode_instruction", row_instr[r], decode_instruction);
    // Writes to x0 never count as a destination
    m_writer[m_decode_ptr] = row_uses_rd[r] && (row_rd[r] != 5'd0);
    decode_advance = 1'b1;
    decode_uses_rd = row_uses_rd[r];
    decode_rd_addr = row_rd[r];
    next_cycle();
    decode_advance = 1'b0;
    m_decode_ptr = m_decode_ptr + 3'd1;
endtask

task automatic issue_row(int r);
    if (row_multi[r]) begin
        m_wb_open[m_issue_ptr] = 1'b1;
        wbq_id.push_back(m_issue_ptr);
        wbq_due.push_back(cycle_count + row_delay[r]);
    end
    instruction_issued = 1'b1;
    issue_pending_wb = row_multi[r];
    issued_total++;
    next_cycle();
    instruction_issued = 1'b0;
    issue_pending_wb = 1'b0;
    m_issue_ptr = m_issue_ptr + 3'd1;
endtask

task automatic flush_front();
    fetch_flush = 1'b1;
    next_cycle();
    fetch_flush = 1'b0;
    // Front end rewinds to the oldest unissued ID
    m_pc_ptr = m_issue_ptr;
    m_fetch_ptr = m_issue_ptr;
    m_decode_ptr = m_issue_ptr;
endtask

task automatic wait_drain();
    int k;
    k = 0;
    while ((retired_total != issued_total || post_issue_count != 4'd0) && k < DRAIN_LIMIT) begin
        next_cycle();
        k++;
    end
    if (retired_total != issued_total || post_issue_count != 4'd0)
        report_error("issued instructions did not all retire in time");
endtask

task automatic run_batch(int first, int last, bit toggle_exc);
    for (int r = first; r <= last; r++)
        assign_row(r);
    for (int r = first; r <= last; r++)
        fetch_row(r);
    for (int r = first; r <= last; r++)
        decode_row(r);
    for (int r = first; r <= last; r++) begin
        if (toggle_exc)
            exception_pending = r[0];
        issue_row(r);
    end
endtask

//////////////////////////////////////////////////////////////////////
// Tests
//////////////////////////////////////////////////////////////////////

task automatic verify_reset_state();
    start_test("reset_state");
    if (!pc_id_available)
        report_mismatch("pc_id_available", 32'd1, 32'(pc_id_available));
    if (decode_valid)
        report_mismatch("decode_valid", 32'd0, 32'(decode_valid));
    if (retire_port_valid[0])
        report_mismatch("retire_port_valid[0]", 32'd0, 32'(retire_port_valid[0]));
    if (retire_port_valid[1])
        report_mismatch("retire_port_valid[1]", 32'd0, 32'(retire_port_valid[1]));
    if (retire_rd_valid)
        report_mismatch("retire_rd_valid", 32'd0, 32'(retire_rd_valid));
    if (retire_count != 4'd0)
        report_mismatch("retire_count", 32'd0, 32'(retire_count));
    if (pc_id != 3'd0)
        report_mismatch("pc_id", 32'd0, 32'(pc_id));
    if (retire_ids[0] != 3'd0)
        report_mismatch("retire_ids[0]", 32'd0, 32'(retire_ids[0]));
    if (retire_ids[1] != 3'd1)
        report_mismatch("retire_ids[1]", 32'd1, 32'(retire_ids[1]));
    finish_test();
endtask

task automatic fill_id_pool();
    start_test("alloc_limit");
    for (int r = 0; r < 8; r++)
        assign_row(r);
    if (pc_id_available)
        report_mismatch("pc_id_available", 32'd0, 32'(pc_id_available));
    if (pc_id != 3'd0)
        report_mismatch("pc_id", 32'd0, 32'(pc_id));
    fetch_row(0);
    decode_row(0);
    issue_row(0);
    wait_drain();
    if (!pc_id_available)
        report_mismatch("pc_id_available", 32'd1, 32'(pc_id_available));
    // Drop the seven unissued IDs
    flush_front();
    finish_test();
endtask

task automatic read_back_decode();
    start_test("decode_readback");
    run_batch(0, 3, 1'b0);
    wait_drain();
    finish_test();
endtask

task automatic check_retire_rules();
    start_test("retire_rules");
    run_batch(4, 7, 1'b1);
    exception_pending = 1'b1;
    wait_drain();
    exception_pending = 1'b0;
    finish_test();
endtask

task automatic hold_for_writeback();
    start_test("writeback_hold");
    run_batch(8, 11, 1'b0);
    // Rows stacked behind a held writeback meet a pending exception as they drain
    exception_pending = 1'b1;
    wait_drain();
    exception_pending = 1'b0;
    for (int i = 0; i < 8; i++) begin
        if (m_wb_open[i])
            report_error("a writeback was never delivered");
    end
    finish_test();
endtask

task automatic flush_fetch_side();
    start_test("fetch_flush");
    run_batch(12, 13, 1'b0);
    for (int r = 14; r <= 16; r++)
        assign_row(r);
    for (int r = 14; r <= 16; r++)
        fetch_row(r);
    if (!decode_valid)
        report_mismatch("decode_valid", 32'd1, 32'(decode_valid));
    flush_front();
    if (pc_id != m_issue_ptr)
        report_mismatch("pc_id", 32'(m_issue_ptr), 32'(pc_id));
    if (fetch_id != m_issue_ptr)
        report_mismatch("fetch_id", 32'(m_issue_ptr), 32'(fetch_id));
    if (decode_id != m_issue_ptr)
        report_mismatch("decode_id", 32'(m_issue_ptr), 32'(decode_id));
    if (decode_valid)
        report_mismatch("decode_valid", 32'd0, 32'(decode_valid));
    wait_drain();
    finish_test();
endtask

/* sim/id_manager_tb.sv */
`timescale 1ns/1ps

module id_manager_tb;

    // Up to 60 cycles for each of the six tests plus margin
    localparam int TIMEOUT_CYCLES = 400;
    localparam int DRAIN_LIMIT = 60;
    localparam int NUM_ROWS = 17;

    logic clk;
    logic rst;
    logic pc_id_assigned;
    logic [31:0] if_pc;
    logic fetch_complete;
    logic [31:0] fetch_instruction;
    logic fetch_flush;
    logic [2:0] pc_id;
    logic [2:0] fetch_id;
    logic pc_id_available;
    logic decode_advance;
    logic decode_uses_rd;
    logic [4:0] decode_rd_addr;
    logic decode_valid;
    logic [2:0] decode_id;
    logic [31:0] decode_pc;
    logic [31:0] decode_instruction;
    logic instruction_issued;
    logic issue_pending_wb;
    logic wb_valid;
    logic [2:0] wb_id;
    logic exception_pending;
    logic [2:0] retire_ids [2];
    logic retire_port_valid [2];
    logic [3:0] retire_count;
    logic retire_rd_valid;
    logic [2:0] retire_rd_id;
    logic [3:0] post_issue_count;

    // Scoreboard state
    int errors;
    int tests_run;
    int tests_failed;
    int cycle_count;
    int seed;
    int issued_total;
    int retired_total;
    logic [2:0] m_pc_ptr;
    logic [2:0] m_fetch_ptr;
    logic [2:0] m_decode_ptr;
    logic [2:0] m_issue_ptr;
    logic [2:0] m_retire_ptr;
    // Writer flag per ID taken at decode
    bit m_writer [8];
    // Set from issue until the writeback has been driven
    bit m_wb_open [8];
    bit prev_exc;
    // Outstanding writebacks with the oldest first
    logic [2:0] wbq_id [$];
    int wbq_due [$];

    id_manager i_id_manager (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("MISMATCH %s: expected %h, got %h", name, expected, actual);
        errors++;
    endtask

    task automatic report_error(string what);
        $display("ERROR: %s", what);
        errors++;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    `include "id_manager_tests.svh"

    //////////////////////////////////////////////////////////////////////
    // Retire monitor sampled mid-cycle where outputs are stable
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin : retire_monitor
        int n_valid;
        int n_writers;
        logic [2:0] wid;
        n_valid = 0;
        n_writers = 0;
        wid = '0;
        if (!rst) begin
            for (int i = 0; i < 2; i++) begin
                if (retire_port_valid[i]) begin
                    // Ports must form one block from port 0
                    if (i > 0 && !retire_port_valid[i-1])
                        report_error("retire port 1 valid without port 0");
                    if (retire_ids[i] != 3'(m_retire_ptr + 3'(i)))
                        report_mismatch("retire_ids", 32'(3'(m_retire_ptr + 3'(i))),
                                        32'(retire_ids[i]));
                    if (m_wb_open[retire_ids[i]])
                        report_error("instruction retired before its writeback");
                    if (m_writer[retire_ids[i]]) begin
                        n_writers++;
                        wid = retire_ids[i];
                    end
                    n_valid++;
                end
            end
            if (32'(retire_count) != n_valid)
                report_mismatch("retire_count", 32'(n_valid), 32'(retire_count));
            if (retire_count > 4'd2)
                report_error("more than two instructions retired in one cycle");
            if (n_writers > 1)
                report_error("two register writers retired in one cycle");
            if (retire_rd_valid != (n_writers == 1))
                report_mismatch("retire_rd_valid", 32'(n_writers == 1), 32'(retire_rd_valid));
            if (retire_rd_valid && n_writers == 1 && retire_rd_id != wid)
                report_mismatch("retire_rd_id", 32'(wid), 32'(retire_rd_id));
            if (prev_exc && retire_count > 4'd1)
                report_error("more than one retired while exception pending");
            m_retire_ptr = m_retire_ptr + 3'(n_valid);
            retired_total += n_valid;
            if (retired_total > issued_total)
                report_error("more instructions retired than issued");
        end
        prev_exc = exception_pending;
    end

    // Answers multicycle results once their delay has passed
    initial begin : wb_driver
        forever begin
            next_cycle();
            wb_valid = 1'b0;
            if (wbq_id.size() > 0 && cycle_count >= wbq_due[0]) begin
                wb_valid = 1'b1;
                wb_id = wbq_id.pop_front();
                void'(wbq_due.pop_front());
                m_wb_open[wb_id] = 1'b0;
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst = 1'b1;
        pc_id_assigned = 1'b0;
        if_pc = '0;
        fetch_complete = 1'b0;
        fetch_instruction = '0;
        fetch_flush = 1'b0;
        decode_advance = 1'b0;
        decode_uses_rd = 1'b0;
        decode_rd_addr = '0;
        instruction_issued = 1'b0;
        issue_pending_wb = 1'b0;
        wb_valid = 1'b0;
        wb_id = '0;
        exception_pending = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        issued_total = 0;
        retired_total = 0;
        m_pc_ptr = '0;
        m_fetch_ptr = '0;
        m_decode_ptr = '0;
        m_issue_ptr = '0;
        m_retire_ptr = '0;
        prev_exc = 1'b0;
        seed = 32'h76fc;
        init_table();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        verify_reset_state();
        fill_id_pool();
        read_back_decode();
        check_retire_rules();
        hold_for_writeback();
        flush_fetch_side();
        $display("summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* id_manager.f */
+incdir+sim
common/id_pkg.sv
src/id_allocator.sv
src/metadata_tables.sv
retire/writeback_tracker.sv
retire/retire_select.sv
src/id_manager.sv
sim/id_manager_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ID manager testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module id_manager_tb -f id_manager.f \
    -o id_manager_sim > build.log 2>&1 &&
./obj_dir/id_manager_sim > sim.log 2>&1 ||
{ echo "build or simulation run failed, see build.log and sim.log"; exit 1; }
grep -q "FAIL: see errors above" sim.log &&
{ echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"
exit 0
